/* project.f */
+incdir+tb
common/rvfi_chk_pkg.sv
source/rvfi_capture.sv
checker/rvfi_rule_check.sv
checker/rvfi_count_check.sv
source/rvfi_err_report.sv
source/rvfi_monitor_top.sv
tb/tb_rvfi_monitor.sv

/* tb/rvfi_monitor_tests.svh */
// Directed test sequences and record drivers for the retirement trace checker testbench

  function automatic rule_vec_t one_hot_rule(input rule_id_t id);
    return rule_vec_t'(1) << id;
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk_i);
  endtask

  // Hold the record for one clock, then drop back to idle
  task automatic commit_record();
    rvfi_valid = 1'b1;
    @(negedge clk_i);
    clear_record();
  endtask

  task automatic bus_transfer();
    bus_valid = 1'b1;
    // Random wait states until the slave accepts
    do begin
      bus_ready = ($random(seed) & 1) != 0;
      @(negedge clk_i);
    end while (!bus_ready);
    bus_valid = 1'b0;
    bus_ready = 1'b0;
  endtask

  task automatic ack_irq();
    irq_ack = 1'b1;
    @(negedge clk_i);
    irq_ack = 1'b0;
  endtask

  task automatic plain_insn(input reg_addr_t rs1_a, input xlen_t rs1_d,
                            input reg_addr_t rs2_a, input xlen_t rs2_d, input logic sync);
    rvfi_rs1_addr  = rs1_a;
    rvfi_rs1_rdata = rs1_d;
    rvfi_rs2_addr  = rs2_a;
    rvfi_rs2_rdata = rs2_d;
    rvfi_intr_exc  = sync;
    commit_record();
  endtask

  task automatic take_exception(input cause_t cause, input xlen_t wdata, input xlen_t wmask);
    rvfi_trap_exc       = 1'b1;
    rvfi_trap_exc_cause = cause;
    rvfi_mcause_wdata   = wdata;
    rvfi_mcause_wmask   = wmask;
    commit_record();
  endtask

  task automatic take_interrupt(input cause_t cause, input logic sync);
    rvfi_intr_int   = 1'b1;
    rvfi_intr_exc   = sync;
    rvfi_intr_cause = cause;
    commit_record();
  endtask

  task automatic enter_debug(input dbg_cause_t cause, input dbg_cause_t dcsr_cause);
    rvfi_dbg            = cause;
    rvfi_dbg_mode       = 1'b1;
    rvfi_dcsr_rdata     = xlen_t'(dcsr_cause) << DCSR_CAUSE_LSB;
    rvfi_trap_dbg       = 1'b1;
    rvfi_trap_dbg_cause = cause;
    commit_record();
  endtask

  task automatic mem_access(input logic [NMEM*MEM_MASK_W-1:0] rmask,
                            input logic [NMEM*MEM_MASK_W-1:0] wmask);
    rvfi_mem_rmask = rmask;
    rvfi_mem_wmask = wmask;
    commit_record();
  endtask

  // Outputs trail the last record by three cycles, one more for the count rules
  task automatic verify_outputs(input rule_vec_t exp_rules, input rule_id_t exp_first,
                                input err_cnt_t exp_count, input string name);
    wait_cycles(5);
    rules_equal(error_rules, exp_rules, name);
    rule_id_equal(first_rule, exp_first, name);
    err_count_equal(error_count, exp_count, name);
    // The summary flag is up whenever any rule has failed
    flag_equal(error, exp_rules != '0, name);
  endtask

  task automatic clean_stream();
    cause_t legal_irq[5];
    cause_t exc_c;
    xlen_t  rs1_d;
    xlen_t  rs2_d;
    legal_irq = '{11'd3, 11'd7, 11'd11, 11'd16, 11'd31};
    pulse_reset();
    for (int i = 0; i < 40; i++) begin
      // Register file still reads zero on the first retirement
      rs1_d = (i == 0) ? '0 : xlen_t'($random(seed));
      rs2_d = (i == 0) ? '0 : xlen_t'($random(seed));
      case (i % 8)
        2: begin
          bus_transfer();
          mem_access(4'hf, 4'h0);
        end
        3: begin
          bus_transfer();
          mem_access(4'h0, 4'h3);
        end
        4: begin
          exc_c = (i % 16 == 4) ? 11'd2 : 11'd11;
          take_exception(exc_c, xlen_t'(exc_c), '1);
        end
        5: plain_insn(5'd10, rs1_d, 5'd11, rs2_d, 1'b1);
        6: begin
          ack_irq();
          take_interrupt(legal_irq[i / 8], 1'b0);
        end
        7: enter_debug(3'd2, 3'd2);
        default: plain_insn(reg_addr_t'(i + 1), rs1_d, reg_addr_t'(i + 2), rs2_d, 1'b0);
      endcase
    end
    verify_outputs('0, rule_id_t'(0), '0, "clean stream");
  endtask

  task automatic reset_values();
    pulse_reset();
    plain_insn(5'd5, 32'h1234_5678, 5'd0, 32'h0bad_0001, 1'b0);
    plain_insn(5'd5, 32'hffff_0000, 5'd6, 32'h0000_0001, 1'b0);
    verify_outputs(one_hot_rule(RULE_RS1_RESET), RULE_RS1_RESET, 16'd1, "reset values");
  endtask

  task automatic cause_mismatch();
    rule_vec_t exp;
    exp = one_hot_rule(RULE_DBG_CAUSE) | one_hot_rule(RULE_EXC_CAUSE) |
          one_hot_rule(RULE_EXC_MCAUSE);
    pulse_reset();
    plain_insn(5'd0, '0, 5'd0, '0, 1'b0);
    enter_debug(3'd3, 3'd1);
    plain_insn(5'd2, xlen_t'($random(seed)), 5'd3, xlen_t'($random(seed)), 1'b0);
    take_exception(11'd5, 32'h8000_0007, '1);
    verify_outputs(exp, RULE_DBG_CAUSE, 16'd3, "cause mismatch");
  endtask

  task automatic irq_causes();
    rule_vec_t exp;
    exp = one_hot_rule(RULE_IRQ_LEGAL) | one_hot_rule(RULE_IRQ_NO_CAUSE) |
          one_hot_rule(RULE_HANDLER_AMBIG);
    pulse_reset();
    ack_irq();
    take_interrupt(11'd16, 1'b0);
    ack_irq();
    take_interrupt(11'd1025, 1'b0);
    ack_irq();
    take_interrupt(11'd12, 1'b0);
    ack_irq();
    take_interrupt(11'd0, 1'b0);
    ack_irq();
    take_interrupt(11'd16, 1'b1);
    verify_outputs(exp, RULE_IRQ_LEGAL, 16'd4, "interrupt causes");
  endtask

  task automatic overreport();
    rule_vec_t exp;
    exp = one_hot_rule(RULE_MEM_OVERREPORT) | one_hot_rule(RULE_IRQ_OVERREPORT) |
          one_hot_rule(RULE_SYNC_CAUSE);
    pulse_reset();
    mem_access(4'hf, 4'h0);
    take_interrupt(11'd16, 1'b0);
    plain_insn(5'd1, xlen_t'($random(seed)), 5'd2, xlen_t'($random(seed)), 1'b0);
    plain_insn(5'd3, xlen_t'($random(seed)), 5'd4, xlen_t'($random(seed)), 1'b1);
    verify_outputs(exp, RULE_MEM_OVERREPORT, 16'd3, "over-reporting");
  endtask

  task automatic sticky_flags();
    rule_vec_t exp;
    exp = one_hot_rule(RULE_EXC_NO_CAUSE) | one_hot_rule(RULE_IRQ_LEGAL) |
          one_hot_rule(RULE_DBG_CAUSE);
    pulse_reset();
    take_exception(11'd0, 32'h0, '1);
    wait_cycles(3);
    ack_irq();
    take_interrupt(11'd12, 1'b0);
    wait_cycles(3);
    enter_debug(3'd3, 3'd1);
    verify_outputs(exp, RULE_EXC_NO_CAUSE, 16'd3, "sticky flags");
  endtask

/* tb/tb_rvfi_monitor.sv */
// Testbench top for the retirement trace checker, drives directed trace sequences into the DUT
`timescale 1ns/10ps

module tb_rvfi_monitor import rvfi_chk_pkg::*; ();

  localparam int NMEM = 1;
  // Six tests take a few hundred cycles together, the limit leaves wide margin
  localparam int TIMEOUT_CYCLES = 2000;

  logic                       clk_i;
  logic                       rst_ni;
  logic                       rvfi_valid;
  reg_addr_t                  rvfi_rs1_addr;
  reg_addr_t                  rvfi_rs2_addr;
  xlen_t                      rvfi_rs1_rdata;
  xlen_t                      rvfi_rs2_rdata;
  dbg_cause_t                 rvfi_dbg;
  logic                       rvfi_dbg_mode;
  xlen_t                      rvfi_dcsr_rdata;
  logic                       rvfi_trap_exc;
  cause_t                     rvfi_trap_exc_cause;
  logic                       rvfi_trap_dbg;
  dbg_cause_t                 rvfi_trap_dbg_cause;
  logic                       rvfi_intr_int;
  logic                       rvfi_intr_exc;
  cause_t                     rvfi_intr_cause;
  xlen_t                      rvfi_mcause_wdata;
  xlen_t                      rvfi_mcause_wmask;
  logic [NMEM*MEM_MASK_W-1:0] rvfi_mem_rmask;
  logic [NMEM*MEM_MASK_W-1:0] rvfi_mem_wmask;
  logic                       bus_valid;
  logic                       bus_ready;
  logic                       irq_ack;
  logic                       error;
  rule_vec_t                  error_rules;
  rule_id_t                   first_rule;
  err_cnt_t                   error_count;

  integer seed   = 63166;
  int     cycles = 0;

  rvfi_monitor_top #(
    .CLIC          (1'b0),
    .CLIC_ID_WIDTH (5),
    .NMEM          (NMEM)
  ) u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("Simulation timed out after %0d cycles", TIMEOUT_CYCLES));
    end
  end

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic rules_equal(input rule_vec_t got, input rule_vec_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH at %0t: %s error_rules got %b expected %b",
                          $time, what, got, exp));
    end
  endtask

  task automatic rule_id_equal(input rule_id_t got, input rule_id_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH at %0t: %s first_rule got %0d expected %0d",
                          $time, what, got, exp));
    end
  endtask

  task automatic err_count_equal(input err_cnt_t got, input err_cnt_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH at %0t: %s error_count got %0d expected %0d",
                          $time, what, got, exp));
    end
  endtask

  task automatic flag_equal(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH at %0t: %s error got %b expected %b",
                          $time, what, got, exp));
    end
  endtask

  // Idle trace record, nothing retiring
  task automatic clear_record();
    rvfi_valid          = 1'b0;
    rvfi_rs1_addr       = '0;
    rvfi_rs2_addr       = '0;
    rvfi_rs1_rdata      = '0;
    rvfi_rs2_rdata      = '0;
    rvfi_dbg            = '0;
    rvfi_dbg_mode       = 1'b0;
    rvfi_dcsr_rdata     = '0;
    rvfi_trap_exc       = 1'b0;
    rvfi_trap_exc_cause = '0;
    rvfi_trap_dbg       = 1'b0;
    rvfi_trap_dbg_cause = '0;
    rvfi_intr_int       = 1'b0;
    rvfi_intr_exc       = 1'b0;
    rvfi_intr_cause     = '0;
    rvfi_mcause_wdata   = '0;
    rvfi_mcause_wmask   = '0;
    rvfi_mem_rmask      = '0;
    rvfi_mem_wmask      = '0;
  endtask

  task automatic quiet_inputs();
    clear_record();
    bus_valid = 1'b0;
    bus_ready = 1'b0;
    irq_ack   = 1'b0;
  endtask

  task automatic pulse_reset();
    @(negedge clk_i);
    rst_ni = 1'b0;
    quiet_inputs();
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
  endtask

  `include "rvfi_monitor_tests.svh"

  initial begin
    rst_ni = 1'b0;
    quiet_inputs();
    clean_stream();
    reset_values();
    cause_mismatch();
    irq_causes();
    overreport();
    sticky_flags();
    $display("No errors");
    $finish;
  end

endmodule

/* source/rvfi_monitor_top.sv */
// Retirement trace checker top, connects capture, rule and count checkers and the reporter
`timescale 1ns/10ps

module rvfi_monitor_top import rvfi_chk_pkg::*; #(
  parameter bit CLIC          = 1'b0,
  parameter int CLIC_ID_WIDTH = 5,
  parameter int NMEM          = 1
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       rvfi_valid,
  input  reg_addr_t                  rvfi_rs1_addr,
  input  reg_addr_t                  rvfi_rs2_addr,
  input  xlen_t                      rvfi_rs1_rdata,
  input  xlen_t                      rvfi_rs2_rdata,
  input  dbg_cause_t                 rvfi_dbg,
  input  logic                       rvfi_dbg_mode,
  input  xlen_t                      rvfi_dcsr_rdata,
  input  logic                       rvfi_trap_exc,
  input  cause_t                     rvfi_trap_exc_cause,
  input  logic                       rvfi_trap_dbg,
  input  dbg_cause_t                 rvfi_trap_dbg_cause,
  input  logic                       rvfi_intr_int,
  input  logic                       rvfi_intr_exc,
  input  cause_t                     rvfi_intr_cause,
  input  xlen_t                      rvfi_mcause_wdata,
  input  xlen_t                      rvfi_mcause_wmask,
  input  logic [NMEM*MEM_MASK_W-1:0] rvfi_mem_rmask,
  input  logic [NMEM*MEM_MASK_W-1:0] rvfi_mem_wmask,
  input  logic                       bus_valid,
  input  logic                       bus_ready,
  input  logic                       irq_ack,
  output logic                       error,
  output rule_vec_t                  error_rules,
  output rule_id_t                   first_rule,
  output err_cnt_t                   error_count
);

  // Captured record
  logic                       rec_valid;
  reg_addr_t                  rec_rs1_addr;
  reg_addr_t                  rec_rs2_addr;
  xlen_t                      rec_rs1_rdata;
  xlen_t                      rec_rs2_rdata;
  dbg_cause_t                 rec_dbg;
  logic                       rec_dbg_mode;
  xlen_t                      rec_dcsr_rdata;
  logic                       rec_trap_exc;
  cause_t                     rec_trap_exc_cause;
  logic                       rec_trap_dbg;
  dbg_cause_t                 rec_trap_dbg_cause;
  logic                       rec_intr_int;
  logic                       rec_intr_exc;
  cause_t                     rec_intr_cause;
  xlen_t                      rec_mcause_wdata;
  xlen_t                      rec_mcause_wmask;
  logic [NMEM*MEM_MASK_W-1:0] rec_mem_rmask;
  logic [NMEM*MEM_MASK_W-1:0] rec_mem_wmask;
  logic                       first_retire;
  logic                       was_dbg_mode;
  logic                       prev_exc;

  rule_vec_t rule_viol;
  rule_vec_t count_viol;

  rvfi_capture #(.NMEM(NMEM)) u_capture (.*);

  rvfi_rule_check #(
    .CLIC          (CLIC),
    .CLIC_ID_WIDTH (CLIC_ID_WIDTH)
  ) u_rule_check (
    .clk_i, .rst_ni, .rec_valid,
    .rec_rs1_addr, .rec_rs2_addr, .rec_rs1_rdata, .rec_rs2_rdata,
    .rec_dbg, .rec_dbg_mode, .rec_dcsr_rdata,
    .rec_trap_exc, .rec_trap_exc_cause, .rec_trap_dbg, .rec_trap_dbg_cause,
    .rec_intr_int, .rec_intr_exc, .rec_intr_cause,
    .rec_mcause_wdata, .rec_mcause_wmask,
    .first_retire, .was_dbg_mode, .prev_exc, .rule_viol
  );

  rvfi_count_check #(.NMEM(NMEM)) u_count_check (
    .clk_i, .rst_ni, .bus_valid, .bus_ready, .irq_ack,
    .rec_valid, .rec_mem_rmask, .rec_mem_wmask, .rec_intr_int, .count_viol
  );

  rvfi_err_report u_err_report (
    .clk_i, .rst_ni, .rule_viol, .count_viol,
    .error, .error_rules, .first_rule, .error_count
  );

endmodule

/* source/rvfi_err_report.sv */
// Error reporter, merges violation vectors into sticky flags, first failing rule and error count
`timescale 1ns/10ps

module rvfi_err_report import rvfi_chk_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  rule_vec_t rule_viol,
  input  rule_vec_t count_viol,
  output logic      error,
  output rule_vec_t error_rules,
  output rule_id_t  first_rule,
  output err_cnt_t  error_count
);

  rule_vec_t                 merged;
  logic [$bits(err_cnt_t):0] cnt_sum;

  // Lowest set index wins
  function automatic rule_id_t lowest_rule(rule_vec_t v);
    rule_id_t id;
    id = '0;
    for (int i = NUM_RULES - 1; i >= 0; i--) begin
      if (v[i]) begin
        id = rule_id_t'(i);
      end
    end
    return id;
  endfunction

  function automatic err_cnt_t ones(rule_vec_t v);
    err_cnt_t n;
    n = '0;
    for (int i = 0; i < NUM_RULES; i++) begin
      n = n + err_cnt_t'(v[i]);
    end
    return n;
  endfunction

  assign merged  = rule_viol | count_viol;
  assign cnt_sum = {1'b0, error_count} + {1'b0, ones(merged)};
  assign error   = |error_rules;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      error_rules <= '0;
      first_rule  <= '0;
      error_count <= '0;
    end else if (merged != '0) begin
      error_rules <= error_rules | merged;
      // Nothing sticky yet means this is the first failing merge
      if (error_rules == '0) begin
        first_rule <= lowest_rule(merged);
      end
      // Saturate instead of wrapping
      error_count <= cnt_sum[$bits(err_cnt_t)] ? '1 : cnt_sum[$bits(err_cnt_t)-1:0];
    end
  end

  a_count_monotonic: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    error_count >= $past(error_count)
  );

endmodule

/* checker/rvfi_count_check.sv */
// Event count checker, compares trace memory accesses and interrupts with bus and ack activity
`timescale 1ns/10ps

module rvfi_count_check import rvfi_chk_pkg::*; #(
  parameter int NMEM = 1
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       bus_valid,
  input  logic                       bus_ready,
  input  logic                       irq_ack,
  input  logic                       rec_valid,
  input  logic [NMEM*MEM_MASK_W-1:0] rec_mem_rmask,
  input  logic [NMEM*MEM_MASK_W-1:0] rec_mem_wmask,
  input  logic                       rec_intr_int,
  output rule_vec_t                  count_viol
);

  cnt_t bus_cnt;
  cnt_t ack_cnt;
  cnt_t mem_cnt;
  cnt_t irq_cnt;
  cnt_t mem_new;
  logic mem_over;
  logic irq_over;
  logic mem_over_q;
  logic irq_over_q;
  logic mem_flag;
  logic irq_flag;

  // One access per slot and direction with any mask bit set
  always_comb begin
    mem_new = '0;
    if (rec_valid) begin
      for (int i = 0; i < NMEM; i++) begin
        if (|rec_mem_rmask[i*MEM_MASK_W +: MEM_MASK_W]) begin
          mem_new = mem_new + 1'b1;
        end
        if (|rec_mem_wmask[i*MEM_MASK_W +: MEM_MASK_W]) begin
          mem_new = mem_new + 1'b1;
        end
      end
    end
  end

  assign mem_over = mem_cnt > bus_cnt;
  assign irq_over = irq_cnt > ack_cnt;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bus_cnt    <= '0;
      ack_cnt    <= '0;
      mem_cnt    <= '0;
      irq_cnt    <= '0;
      mem_over_q <= 1'b0;
      irq_over_q <= 1'b0;
      mem_flag   <= 1'b0;
      irq_flag   <= 1'b0;
    end else begin
      bus_cnt    <= bus_cnt + cnt_t'(bus_valid && bus_ready);
      ack_cnt    <= ack_cnt + cnt_t'(irq_ack);
      mem_cnt    <= mem_cnt + mem_new;
      irq_cnt    <= irq_cnt + cnt_t'(rec_valid && rec_intr_int);
      mem_over_q <= mem_over;
      irq_over_q <= irq_over;
      // Report once when the trace first runs ahead
      mem_flag   <= mem_over && !mem_over_q;
      irq_flag   <= irq_over && !irq_over_q;
    end
  end

  always_comb begin
    count_viol = '0;
    count_viol[RULE_MEM_OVERREPORT] = mem_flag;
    count_viol[RULE_IRQ_OVERREPORT] = irq_flag;
  end

  a_counts_monotonic: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (bus_cnt >= $past(bus_cnt)) && (ack_cnt >= $past(ack_cnt)) &&
    (mem_cnt >= $past(mem_cnt)) && (irq_cnt >= $past(irq_cnt))
  );

endmodule

/* checker/rvfi_rule_check.sv */
// Record rule checker, evaluates the cause and register rules on each captured retirement
`timescale 1ns/10ps

module rvfi_rule_check import rvfi_chk_pkg::*; #(
  parameter bit CLIC          = 1'b0,
  parameter int CLIC_ID_WIDTH = 5
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       rec_valid,
  input  reg_addr_t  rec_rs1_addr,
  input  reg_addr_t  rec_rs2_addr,
  input  xlen_t      rec_rs1_rdata,
  input  xlen_t      rec_rs2_rdata,
  input  dbg_cause_t rec_dbg,
  input  logic       rec_dbg_mode,
  input  xlen_t      rec_dcsr_rdata,
  input  logic       rec_trap_exc,
  input  cause_t     rec_trap_exc_cause,
  input  logic       rec_trap_dbg,
  input  dbg_cause_t rec_trap_dbg_cause,
  input  logic       rec_intr_int,
  input  logic       rec_intr_exc,
  input  cause_t     rec_intr_cause,
  input  xlen_t      rec_mcause_wdata,
  input  xlen_t      rec_mcause_wmask,
  input  logic       first_retire,
  input  logic       was_dbg_mode,
  input  logic       prev_exc,
  output rule_vec_t  rule_viol
);

  xlen_t      mcause_masked;
  dbg_cause_t dcsr_cause;
  logic       exc_outside_dbg;
  logic       irq_legal;
  logic       irq_need_cause;
  rule_vec_t  viol_d;

  assign mcause_masked   = rec_mcause_wdata & rec_mcause_wmask;
  assign dcsr_cause      = rec_dcsr_rdata[DCSR_CAUSE_LSB +: $bits(dbg_cause_t)];
  assign exc_outside_dbg = rec_trap_exc && !rec_dbg_mode;

  // Legal interrupt causes depend on the interrupt controller
  if (CLIC) begin : gen_clic
    localparam int unsigned MAX_CLIC_ID = (1 << CLIC_ID_WIDTH) - 1;

    assign irq_legal = (32'(rec_intr_cause) <= MAX_CLIC_ID) ||
                       (rec_intr_cause inside {[IRQ_CAUSE_NMI_LO:IRQ_CAUSE_NMI_HI]});
    // CLIC id 0 is a valid interrupt
    assign irq_need_cause = 1'b0;
  end else begin : gen_clint
    assign irq_legal = rec_intr_cause inside {11'd3, 11'd7, 11'd11, [11'd16:11'd31],
                                              [IRQ_CAUSE_NMI_LO:IRQ_CAUSE_NMI_HI]};
    assign irq_need_cause = 1'b1;
  end

  always_comb begin
    viol_d = '0;
    if (rec_valid) begin
      // Register file reads zero until something has been written
      viol_d[RULE_RS1_RESET] = first_retire && (rec_rs1_addr != '0) &&
                               (rec_rs1_rdata != '0);
      viol_d[RULE_RS2_RESET] = first_retire && (rec_rs2_addr != '0) &&
                               (rec_rs2_rdata != '0);

      // Debug entry cause against dcsr
      viol_d[RULE_DBG_CAUSE] = (rec_dbg != '0) && !was_dbg_mode &&
                               (rec_dbg != dcsr_cause);

      // Exception code against the mcause write, interrupt bit excluded
      viol_d[RULE_EXC_CAUSE] = exc_outside_dbg &&
          (xlen_t'(rec_trap_exc_cause) != {1'b0, mcause_masked[XLEN-2:0]});

      // mcause.interrupt must be written to zero
      viol_d[RULE_EXC_MCAUSE] = exc_outside_dbg &&
          !(rec_mcause_wmask[XLEN-1] && !rec_mcause_wdata[XLEN-1]);

      viol_d[RULE_IRQ_LEGAL] = rec_intr_int && !irq_legal;

      // Every trap kind carries a cause
      viol_d[RULE_EXC_NO_CAUSE] = rec_trap_exc && (rec_trap_exc_cause == '0);
      viol_d[RULE_IRQ_NO_CAUSE] = irq_need_cause && rec_intr_int &&
                                  (rec_intr_cause == '0);
      viol_d[RULE_DBG_NO_CAUSE] = rec_trap_dbg && (rec_trap_dbg_cause == '0);

      // A sync handler only follows an announced exception
      viol_d[RULE_SYNC_CAUSE] = !rec_intr_int && (rec_intr_exc != prev_exc);

      viol_d[RULE_HANDLER_AMBIG] = rec_intr_exc && rec_intr_int;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rule_viol <= '0;
    end else begin
      rule_viol <= viol_d;
    end
  end

  // Flags only follow a captured record
  a_viol_needs_record: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !$past(rec_valid) |-> (rule_viol == '0)
  );

endmodule

/* source/rvfi_capture.sv */
// Trace capture stage, registers each retired record and keeps the retirement history bits
`timescale 1ns/10ps

module rvfi_capture import rvfi_chk_pkg::*; #(
  parameter int NMEM = 1
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       rvfi_valid,
  input  reg_addr_t                  rvfi_rs1_addr,
  input  reg_addr_t                  rvfi_rs2_addr,
  input  xlen_t                      rvfi_rs1_rdata,
  input  xlen_t                      rvfi_rs2_rdata,
  input  dbg_cause_t                 rvfi_dbg,
  input  logic                       rvfi_dbg_mode,
  input  xlen_t                      rvfi_dcsr_rdata,
  input  logic                       rvfi_trap_exc,
  input  cause_t                     rvfi_trap_exc_cause,
  input  logic                       rvfi_trap_dbg,
  input  dbg_cause_t                 rvfi_trap_dbg_cause,
  input  logic                       rvfi_intr_int,
  input  logic                       rvfi_intr_exc,
  input  cause_t                     rvfi_intr_cause,
  input  xlen_t                      rvfi_mcause_wdata,
  input  xlen_t                      rvfi_mcause_wmask,
  input  logic [NMEM*MEM_MASK_W-1:0] rvfi_mem_rmask,
  input  logic [NMEM*MEM_MASK_W-1:0] rvfi_mem_wmask,
  output logic                       rec_valid,
  output reg_addr_t                  rec_rs1_addr,
  output reg_addr_t                  rec_rs2_addr,
  output xlen_t                      rec_rs1_rdata,
  output xlen_t                      rec_rs2_rdata,
  output dbg_cause_t                 rec_dbg,
  output logic                       rec_dbg_mode,
  output xlen_t                      rec_dcsr_rdata,
  output logic                       rec_trap_exc,
  output cause_t                     rec_trap_exc_cause,
  output logic                       rec_trap_dbg,
  output dbg_cause_t                 rec_trap_dbg_cause,
  output logic                       rec_intr_int,
  output logic                       rec_intr_exc,
  output cause_t                     rec_intr_cause,
  output xlen_t                      rec_mcause_wdata,
  output xlen_t                      rec_mcause_wmask,
  output logic [NMEM*MEM_MASK_W-1:0] rec_mem_rmask,
  output logic [NMEM*MEM_MASK_W-1:0] rec_mem_wmask,
  output logic                       first_retire,
  output logic                       was_dbg_mode,
  output logic                       prev_exc
);

  // Armed by reset, cleared by the first retirement
  logic first_pending;
  // Debug mode and exception bit of the last retirement seen
  logic dbg_mode_q;
  logic exc_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rec_valid     <= 1'b0;
      first_pending <= 1'b1;
      first_retire  <= 1'b0;
      dbg_mode_q    <= 1'b0;
      exc_q         <= 1'b0;
      was_dbg_mode  <= 1'b0;
      prev_exc      <= 1'b0;
    end else begin
      rec_valid <= rvfi_valid;
      if (rvfi_valid) begin
        first_retire  <= first_pending;
        first_pending <= 1'b0;
        // History travels with the record it precedes
        was_dbg_mode  <= dbg_mode_q;
        prev_exc      <= exc_q;
        dbg_mode_q    <= rvfi_dbg_mode;
        exc_q         <= rvfi_trap_exc;
      end
    end
  end

  // Record payload
  always_ff @(posedge clk_i) begin
    if (rvfi_valid) begin
      rec_rs1_addr       <= rvfi_rs1_addr;
      rec_rs2_addr       <= rvfi_rs2_addr;
      rec_rs1_rdata      <= rvfi_rs1_rdata;
      rec_rs2_rdata      <= rvfi_rs2_rdata;
      rec_dbg            <= rvfi_dbg;
      rec_dbg_mode       <= rvfi_dbg_mode;
      rec_dcsr_rdata     <= rvfi_dcsr_rdata;
      rec_trap_exc       <= rvfi_trap_exc;
      rec_trap_exc_cause <= rvfi_trap_exc_cause;
      rec_trap_dbg       <= rvfi_trap_dbg;
      rec_trap_dbg_cause <= rvfi_trap_dbg_cause;
      rec_intr_int       <= rvfi_intr_int;
      rec_intr_exc       <= rvfi_intr_exc;
      rec_intr_cause     <= rvfi_intr_cause;
      rec_mcause_wdata   <= rvfi_mcause_wdata;
      rec_mcause_wmask   <= rvfi_mcause_wmask;
      rec_mem_rmask      <= rvfi_mem_rmask;
      rec_mem_wmask      <= rvfi_mem_wmask;
    end
  end

  // The first record out of reset has no earlier retirement behind it
  a_first_no_history: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (rec_valid && first_retire) |-> (!was_dbg_mode && !prev_exc)
  );

endmodule

/* common/rvfi_chk_pkg.sv */
// Retirement-trace checker package with the shared vector types, rule indices and cause limits
package rvfi_chk_pkg;

  // Core data width, fixed for this checker
  localparam int unsigned XLEN = 32;

  // Byte mask bits per trace memory slot
  localparam int unsigned MEM_MASK_W = XLEN / 8;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [2:0]      dbg_cause_t;
  typedef logic [10:0]     cause_t;

  localparam int unsigned NUM_RULES = 13;

  typedef logic [NUM_RULES-1:0] rule_vec_t;
  typedef logic [3:0]           rule_id_t;
  typedef logic [31:0]          cnt_t;
  typedef logic [15:0]          err_cnt_t;

  // Record rules, evaluated by the rule checker
  localparam rule_id_t RULE_RS1_RESET      = 4'd0;
  localparam rule_id_t RULE_RS2_RESET      = 4'd1;
  localparam rule_id_t RULE_DBG_CAUSE      = 4'd2;
  localparam rule_id_t RULE_EXC_CAUSE      = 4'd3;
  localparam rule_id_t RULE_EXC_MCAUSE     = 4'd4;
  localparam rule_id_t RULE_IRQ_LEGAL      = 4'd5;
  localparam rule_id_t RULE_EXC_NO_CAUSE   = 4'd6;
  localparam rule_id_t RULE_IRQ_NO_CAUSE   = 4'd7;
  localparam rule_id_t RULE_DBG_NO_CAUSE   = 4'd8;
  localparam rule_id_t RULE_SYNC_CAUSE     = 4'd9;
  localparam rule_id_t RULE_HANDLER_AMBIG  = 4'd10;

  // Event count rules, evaluated by the count checker
  localparam rule_id_t RULE_MEM_OVERREPORT = 4'd11;
  localparam rule_id_t RULE_IRQ_OVERREPORT = 4'd12;

  // dcsr.cause sits in bits 8 to 6
  localparam int unsigned DCSR_CAUSE_LSB = 6;

  // Non-maskable interrupt causes
  localparam cause_t IRQ_CAUSE_NMI_LO = 11'd1024;
  localparam cause_t IRQ_CAUSE_NMI_HI = 11'd1027;

endpackage
